//--- Makefile
SRCS := $(shell cat list.f)

obj_dir/Vtb_pat: list.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_pat -o Vtb_pat -f list.f

run: obj_dir/Vtb_pat
	-./obj_dir/Vtb_pat > sim.log 2>&1
	cat sim.log
	! grep -q "Something failed" sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- list.f
pat_pkg.sv
pat_alu.sv
pat_data_mem.sv
pat_decode.sv
pat_execute.sv
pat_core.sv
pat_core_asserts.sv
tb_pat.sv

//--- pat_alu.sv
`default_nettype none

module pat_alu
(
	input wire pat_pkg::alu_op_t i_func,
	input wire pat_pkg::data_t i_a,  // accumulator
	input wire pat_pkg::data_t i_b,  // operand
	output pat_pkg::data_t o_y
);

	import pat_pkg::*;

	logic [2:0] shamt;  // shifts use low 3 bits only
	data_t shl_y;
	data_t shr_y;
	data_t asr_y;
	data_t ones_mask;
	data_t shlo_y;

	assign shamt = i_b[2:0];

	// ====================
	// shifters
	// ====================
	assign shl_y = i_a << shamt;
	assign shr_y = i_a >> shamt;
	assign asr_y = $signed(i_a) >>> shamt;  // sign bit copied in

	// shlo: shift left, vacated bits become ones
	assign ones_mask = ~({D_WIDTH{1'b1}} << shamt);  // low shamt bits set
	assign shlo_y = shl_y | ones_mask;

	// ====================
	// function select
	// ====================
	always_comb
	begin
		case (i_func)
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_ADD: o_y = i_a + i_b;  // wraps, no carry kept
			ALU_SUB: o_y = i_a - i_b;
			ALU_NOT: o_y = ~i_a;  // b ignored
			ALU_SHL: o_y = shl_y;
			ALU_SHLO: o_y = shlo_y;
			ALU_SHR: o_y = shr_y;
			ALU_ASR: o_y = asr_y;
			ALU_PASS_B: o_y = i_b;  // ldm path
			default: o_y = i_b;
		endcase
	end

endmodule

`default_nettype wire

//--- pat_core.sv
`default_nettype none

module pat_core
#(
	parameter int DMEM_WORDS = 32
)
(
	input wire logic clk,
	input wire logic reset,
	input wire pat_pkg::instr_t i_instr,
	input wire pat_pkg::data_t i_inputs,
	output pat_pkg::data_t o_acc,
	output pat_pkg::data_t o_outputs
);

	import pat_pkg::*;

	data_t rd_addr;  // decode -> dmem
	data_t rd_data;  // dmem -> decode, same cycle
	dec_op_t dec_op;  // decode -> execute
	mem_wr_t mem_wr;  // execute -> dmem

	// ====================
	// stages
	// ====================
	pat_decode u_pat_decode
	(
		.clk(clk),
		.reset(reset),
		.i_instr(i_instr),
		.i_rd_data(rd_data),
		.o_rd_addr(rd_addr),
		.o_op(dec_op)
	);

	pat_data_mem
	#(
		.DMEM_WORDS(DMEM_WORDS)
	)
	u_pat_data_mem
	(
		.clk(clk),
		.reset(reset),
		.i_rd_addr(rd_addr),
		.i_wr(mem_wr),
		.o_rd_data(rd_data)
	);

	pat_execute u_pat_execute
	(
		.clk(clk),
		.reset(reset),
		.i_op(dec_op),
		.i_inputs(i_inputs),
		.o_wr(mem_wr),
		.o_acc(o_acc),
		.o_outputs(o_outputs)
	);

endmodule

`default_nettype wire

//--- pat_core_asserts.sv
`default_nettype none

module pat_core_asserts
(
	input wire logic clk,
	input wire logic reset,
	input wire pat_pkg::dec_op_t i_op,
	input wire pat_pkg::mem_wr_t i_wr,
	input wire pat_pkg::data_t i_acc
);

	// ====================
	// execute stage checks
	// ====================
	// decoded op is cleared, so no store while in reset or just out of it
	wr_idle_reset: assert property (@(posedge clk) $past(reset) |-> !i_wr.en)
		else $error("memory write enabled during or right after reset");

	// a store touches neither acc nor the port
	wr_needs_store: assert property (@(posedge clk) disable iff (reset)
		i_wr.en |-> i_op.wr_mem && !i_op.wr_acc && !i_op.do_out)
		else $error("memory write without a plain store op");

	acc_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(i_acc))
		else $error("accumulator unknown after reset");  // acc has a reset value

endmodule

bind pat_execute pat_core_asserts u_pat_core_asserts
(
	.clk(clk),
	.reset(reset),
	.i_op(i_op),
	.i_wr(o_wr),
	.i_acc(o_acc)
);

`default_nettype wire

//--- pat_data_mem.sv
`default_nettype none

module pat_data_mem
#(
	parameter int DMEM_WORDS = 32  // power of two
)
(
	input wire logic clk,
	input wire logic reset,
	input wire pat_pkg::data_t i_rd_addr,
	input wire pat_pkg::mem_wr_t i_wr,
	output pat_pkg::data_t o_rd_data
);

	import pat_pkg::*;

	localparam int AW = $clog2(DMEM_WORDS);  // index bits, addr wraps

	data_t mem [DMEM_WORDS];

	logic [AW-1:0] rd_idx;
	logic [AW-1:0] wr_idx;

	// modulo by dropping upper addr bits
	assign rd_idx = i_rd_addr[AW-1:0];
	assign wr_idx = i_wr.addr[AW-1:0];

	// comb read, same cycle as decode
	assign o_rd_data = mem[rd_idx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// wipe every word
			for (int i = 0; i < DMEM_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (i_wr.en)
		begin
			mem[wr_idx] <= i_wr.data;  // visible to reads after this edge
		end
	end

endmodule

`default_nettype wire

//--- pat_decode.sv
`default_nettype none

module pat_decode
(
	input wire logic clk,
	input wire logic reset,
	input wire pat_pkg::instr_t i_instr,  // new word every cycle
	input wire pat_pkg::data_t i_rd_data,  // comb read data from dmem
	output pat_pkg::data_t o_rd_addr,
	output pat_pkg::dec_op_t o_op
);

	import pat_pkg::*;

	instr_t instr_q;  // stage 1 instruction register

	// instruction fields
	cond_t cond;
	opc_t opc_i8;
	opc_t opc_i3;
	opc_t opc_i0;
	data_t imm8;
	logic [2:0] imm3;

	logic is_i8;
	logic is_i3;
	data_t imm;  // class dependent immediate
	logic mem_op;  // operand from dmem
	dec_op_t dec;

	// ====================
	// field split
	// ====================
	// bits 19:15 and 12 carry nothing here
	assign cond = instr_q[14:13];
	assign opc_i8 = instr_q[11:8];
	assign imm8 = instr_q[7:0];
	assign opc_i3 = instr_q[7:4];  // overlaps imm8
	assign opc_i0 = instr_q[3:0];
	assign imm3 = instr_q[2:0];

	// class from the prefix chain
	assign is_i8 = (opc_i8 != PREFIX);
	assign is_i3 = !is_i8 && (opc_i3 != PREFIX);

	assign imm = is_i8 ? imm8 : {{(D_WIDTH-3){1'b0}}, imm3};  // i3 zero extended

	assign o_rd_addr = imm8;  // memory always addressed by i8 imm

	// ====================
	// opcode decode
	// ====================
	always_comb
	begin
		dec = '0;  // unknown opcode -> no effect
		dec.func = ALU_PASS_B;
		dec.src = SRC_ALU;
		mem_op = 1'b0;
		if (is_i8)
		begin
			case (opc_i8)
				OPC_OR: begin dec.func = ALU_OR; dec.wr_acc = 1'b1; end
				OPC_AND: begin dec.func = ALU_AND; dec.wr_acc = 1'b1; end
				OPC_ADD: begin dec.func = ALU_ADD; dec.wr_acc = 1'b1; end
				OPC_SUB: begin dec.func = ALU_SUB; dec.wr_acc = 1'b1; end
				OPC_ADDM: begin dec.func = ALU_ADD; dec.wr_acc = 1'b1; mem_op = 1'b1; end
				OPC_SUBM: begin dec.func = ALU_SUB; dec.wr_acc = 1'b1; mem_op = 1'b1; end
				OPC_ORM: begin dec.func = ALU_OR; dec.wr_acc = 1'b1; mem_op = 1'b1; end
				OPC_ANDM: begin dec.func = ALU_AND; dec.wr_acc = 1'b1; mem_op = 1'b1; end
				OPC_LDM: begin dec.wr_acc = 1'b1; mem_op = 1'b1; end  // pass_b of mem word
				OPC_LDI: begin dec.src = SRC_IMM; dec.wr_acc = 1'b1; end
				OPC_STAM: dec.wr_mem = 1'b1;
				default: ;  // 1000, 1001, 1010, 1100 unused
			endcase
		end
		else if (is_i3)
		begin
			case (opc_i3)
				OPC_SHL: begin dec.func = ALU_SHL; dec.wr_acc = 1'b1; end
				OPC_SHLO: begin dec.func = ALU_SHLO; dec.wr_acc = 1'b1; end
				OPC_SHR: begin dec.func = ALU_SHR; dec.wr_acc = 1'b1; end
				OPC_ASR: begin dec.func = ALU_ASR; dec.wr_acc = 1'b1; end
				OPC_IN: begin dec.src = SRC_IN; dec.wr_acc = 1'b1; end
				OPC_OUT: dec.do_out = 1'b1;  // old acc to port
				default: ;
			endcase
		end
		else
		begin
			// i0, opcode in low nibble
			case (opc_i0)
				OPC_NOT: begin dec.func = ALU_NOT; dec.wr_acc = 1'b1; end
				OPC_NOP: ;  // explicit nop
				default: ;
			endcase
		end
		dec.cond = cond;
		dec.imm = imm;
		dec.operand = mem_op ? i_rd_data : imm;  // operand select
	end

	// ====================
	// pipeline registers
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q <= NOP_INSTR;
			o_op <= '0;  // all write flags low
		end
		else
		begin
			instr_q <= i_instr;
			o_op <= dec;  // stage 2 decoded op
		end
	end

endmodule

`default_nettype wire

//--- pat_execute.sv
`default_nettype none

module pat_execute
(
	input wire logic clk,
	input wire logic reset,
	input wire pat_pkg::dec_op_t i_op,  // registered decoded op
	input wire pat_pkg::data_t i_inputs,  // sampled at commit
	output pat_pkg::mem_wr_t o_wr,
	output pat_pkg::data_t o_acc,
	output pat_pkg::data_t o_outputs
);

	import pat_pkg::*;

	data_t acc;  // the accumulator
	logic z;  // acc was zero one edge ago
	logic n;  // acc was negative one edge ago
	logic cond_ok;
	data_t alu_y;
	data_t result;

	// ====================
	// condition and result
	// ====================
	always_comb
	begin
		case (i_op.cond)
			COND_Z: cond_ok = z;
			COND_N: cond_ok = n;
			default: cond_ok = 1'b1;  // 10, 11 always
		endcase
	end

	pat_alu u_pat_alu
	(
		.i_func(i_op.func),
		.i_a(acc),
		.i_b(i_op.operand),
		.o_y(alu_y)
	);

	// acc source mux
	always_comb
	begin
		case (i_op.src)
			SRC_IMM: result = i_op.operand;  // ldi
			SRC_IN: result = i_inputs;
			default: result = alu_y;
		endcase
	end

	// ====================
	// commit
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			z <= 1'b0;
			n <= 1'b0;
			o_outputs <= '0;
		end
		else
		begin
			// flags track acc every edge, not only on commit
			z <= (acc == '0);
			n <= acc[D_WIDTH-1];
			if (cond_ok && i_op.wr_acc)
			begin
				acc <= result;
			end
			if (cond_ok && i_op.do_out)
			begin
				o_outputs <= acc;  // value before this edge
			end
		end
	end

	// store goes out comb, memory writes it at the commit edge
	assign o_wr.en = cond_ok && i_op.wr_mem;
	assign o_wr.addr = i_op.imm;
	assign o_wr.data = acc;  // old acc

	assign o_acc = acc;

endmodule

`default_nettype wire

//--- pat_pkg.sv
`default_nettype none

package pat_pkg;

	// ====================
	// widths and base types
	// ====================
	localparam int D_WIDTH = 8;  // fixed by the 8 bit immediate

	typedef logic [D_WIDTH-1:0] data_t;  // acc, operand, memory word
	typedef logic [19:0] instr_t;  // one instruction word
	typedef logic [3:0] opc_t;  // opcode field of any class
	typedef logic [1:0] cond_t;  // commit condition

	// condition codes, 10 and 11 both mean always
	localparam cond_t COND_Z = 2'b00;
	localparam cond_t COND_N = 2'b01;

	// escape into the next class
	localparam opc_t PREFIX = 4'b1111;

	// ====================
	// opcodes
	// ====================
	// i8 class
	localparam opc_t OPC_OR = 4'b0000;
	localparam opc_t OPC_AND = 4'b0001;
	localparam opc_t OPC_ADDM = 4'b0010;
	localparam opc_t OPC_SUBM = 4'b0011;
	localparam opc_t OPC_ADD = 4'b0100;
	localparam opc_t OPC_SUB = 4'b0101;
	localparam opc_t OPC_LDI = 4'b0110;
	localparam opc_t OPC_LDM = 4'b0111;
	localparam opc_t OPC_STAM = 4'b1011;
	localparam opc_t OPC_ORM = 4'b1101;
	localparam opc_t OPC_ANDM = 4'b1110;
	// i3 class
	localparam opc_t OPC_SHL = 4'b0000;
	localparam opc_t OPC_SHLO = 4'b0001;
	localparam opc_t OPC_SHR = 4'b0010;
	localparam opc_t OPC_ASR = 4'b0011;
	localparam opc_t OPC_IN = 4'b0101;
	localparam opc_t OPC_OUT = 4'b1000;
	// i0 class
	localparam opc_t OPC_NOT = 4'b0000;
	localparam opc_t OPC_NOP = 4'b1111;

	localparam instr_t NOP_INSTR = 20'hfffff;  // all prefixes, then i0 nop

	// ====================
	// decoded op
	// ====================
	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_ADD, ALU_SUB, ALU_NOT,
		ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR, ALU_PASS_B
	} alu_op_t;

	// where the new acc value comes from
	typedef enum logic [1:0] {SRC_ALU, SRC_IMM, SRC_IN} src_t;

	typedef struct packed {
		alu_op_t func;
		src_t src;
		data_t operand;  // memory word or immediate
		data_t imm;  // raw immediate, store address
		cond_t cond;
		logic wr_acc;
		logic wr_mem;
		logic do_out;
	} dec_op_t;

	typedef struct packed {
		logic en;
		data_t addr;
		data_t data;
	} mem_wr_t;

endpackage

`default_nettype wire

//--- tb_pat.sv
`default_nettype none

module tb_pat;

	import pat_pkg::*;

	localparam int MEM_WORDS = 32;
	// memory operand ops for the store and load test
	localparam opc_t MEM_OPS [5] = '{OPC_LDM, OPC_ADDM, OPC_SUBM, OPC_ORM, OPC_ANDM};

	logic clk = 1'b0;
	logic reset;
	instr_t i_instr;
	data_t i_inputs;
	data_t o_acc;
	data_t o_outputs;

	integer seed;
	int checks;
	int errors;
	logic ready;  // outputs known after reset
	data_t mem_addr;  // word under test in the memory test

	// ====================
	// cycle model
	// ====================
	data_t m_acc;
	logic m_z;
	logic m_n;
	data_t m_out;
	data_t m_mem [MEM_WORDS];
	instr_t s1_ins;  // instruction register
	instr_t s2_ins;  // decoded op register
	data_t s2_mem;  // word read while s2_ins was decoded

	pat_core
	#(
		.DMEM_WORDS(MEM_WORDS)
	)
	u_pat_core
	(
		.clk(clk),
		.reset(reset),
		.i_instr(i_instr),
		.i_inputs(i_inputs),
		.o_acc(o_acc),
		.o_outputs(o_outputs)
	);

	always #2 clk = ~clk;  // period 4

	function automatic int rnd(input int n);
		rnd = $unsigned($random(seed)) % n;
	endfunction

	// ignored bits left at zero
	function automatic instr_t pack(input cond_t c, input opc_t o8, input data_t low);
		pack = {5'b0, c, 1'b0, o8, low};
	endfunction

	// one model step per rising edge, every value taken from before the edge
	task automatic model_edge();
		data_t acc;
		data_t rd;
		data_t imm;
		logic [2:0] sh;
		logic ok;
		acc = m_acc;
		rd = m_mem[s1_ins[4:0]];  // decode reads at the i8 immediate, 32 words
		imm = s2_ins[7:0];
		sh = s2_ins[2:0];
		ok = (s2_ins[14:13] == 2'b00) ? m_z : (s2_ins[14:13] == 2'b01) ? m_n : 1'b1;
		if (ok && s2_ins[11:8] != PREFIX)
		begin
			case (s2_ins[11:8])
				OPC_OR: m_acc = acc | imm;
				OPC_AND: m_acc = acc & imm;
				OPC_ADD: m_acc = acc + imm;
				OPC_SUB: m_acc = acc - imm;
				OPC_ADDM: m_acc = acc + s2_mem;
				OPC_SUBM: m_acc = acc - s2_mem;
				OPC_ORM: m_acc = acc | s2_mem;
				OPC_ANDM: m_acc = acc & s2_mem;
				OPC_LDM: m_acc = s2_mem;
				OPC_LDI: m_acc = imm;
				OPC_STAM: m_mem[imm[4:0]] = acc;  // old acc, address wraps
				default: ;
			endcase
		end
		else if (ok && s2_ins[7:4] != PREFIX)
		begin
			case (s2_ins[7:4])
				OPC_SHL: m_acc = acc << sh;
				OPC_SHLO: m_acc = (acc << sh) | ((data_t'(1) << sh) - data_t'(1));
				OPC_SHR: m_acc = acc >> sh;
				OPC_ASR: m_acc = (acc >> sh) | (acc[7] ? ~(8'hff >> sh) : 8'h00);
				OPC_IN: m_acc = i_inputs;  // value the DUT sees at this edge
				OPC_OUT: m_out = acc;
				default: ;
			endcase
		end
		else if (ok && s2_ins[3:0] == OPC_NOT)
			m_acc = ~acc;
		m_z = (acc == 8'h00);  // flags lag the acc by one edge
		m_n = acc[7];
		s2_ins = s1_ins;
		s2_mem = rd;
		s1_ins = i_instr;
	endtask

	task automatic compare(input data_t got, input data_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// edge, model, check, then drive the next word 1 unit late
	task automatic cycle(input instr_t ins, input data_t inp);
		@(posedge clk);
		model_edge();
		#1;
		compare(o_acc, m_acc, "o_acc");
		compare(o_outputs, m_out, "o_outputs");
		i_instr = ins;
		i_inputs = inp;
	endtask

	// ====================
	// stimulus
	// ====================
	function automatic instr_t gen(input int mode, input int i);
		cond_t c;
		data_t a;
		int r;
		c = rnd(2) ? 2'b11 : 2'b10;  // both mean always
		a = data_t'($random(seed));
		r = rnd(4);
		gen = pack(c, OPC_LDI, a);
		case (mode)
			0:
			begin
				// ldi then ldm, memory still all zero
				if (i % 2 == 1)
					gen = pack(c, OPC_LDM, a);
			end
			1, 3:
			begin
				if (mode == 3)
					c = cond_t'(rnd(2));  // z or n only
				case (r)
					0: gen = pack(2'b10, OPC_LDI, rnd(3) ? a : 8'h00);  // zeros keep z moving
					1: gen = pack(c, opc_t'(rnd(2) * 4 + rnd(2)), a);  // or and add sub
					2: gen = pack(c, PREFIX, {PREFIX, OPC_NOT});
					default: gen = pack(c, PREFIX, {2'b00, 2'(rnd(4)), a[3:0]});  // shifts
				endcase
			end
			2:
			begin
				// ldi, stam, then k+1 sees the old word and k+2 the new one
				if (i % 4 == 1)
					gen = pack(c, OPC_STAM, mem_addr);
				else if (i % 4 > 1)
					gen = pack(c, MEM_OPS[3'(rnd(5))], mem_addr);
				else
					mem_addr = data_t'($random(seed)) & 8'he7;  // 8 words, wrap bits random
			end
			4:
			begin
				case (r)
					0: gen = pack(c, PREFIX, {OPC_IN, a[3:0]});
					1: gen = pack(c, PREFIX, {OPC_OUT, a[3:0]});
					2: gen = pack(c, OPC_ADD, a);
					default: ;  // ldi
				endcase
			end
			default:
			begin
				gen = instr_t'($random(seed));  // any word, ignored bits too
				if (r == 1)
					gen[11:8] = PREFIX;  // push toward i3
				else if (r == 2)
					gen[11:4] = {PREFIX, PREFIX};  // and i0
			end
		endcase
	endfunction

	task automatic run_test(input string name, input int mode, input int count);
		int err0;
		err0 = errors;
		for (int i = 0; i < count; i++)
			cycle(gen(mode, i), data_t'($random(seed)));
		$display("test %s: %0d instructions, %0d errors", name, count, errors - err0);
	endtask

	// outputs must settle to known values within 10 cycles
	task automatic wait_ready(output logic ok);
		int n;
		n = 0;
		while ($isunknown({o_acc, o_outputs}) && n < 10)
		begin
			cycle(NOP_INSTR, '0);
			n++;
		end
		ok = !$isunknown({o_acc, o_outputs});
		if (!ok)
		begin
			errors++;
			$display("timeout: DUT outputs still unknown 10 cycles after reset");
		end
	endtask

	initial
	begin
		seed = 32'hc3ac7017;
		reset = 1'b1;
		i_instr = NOP_INSTR;
		i_inputs = '0;
		checks = 0;
		errors = 0;
		mem_addr = '0;
		m_acc = '0;
		m_z = 1'b0;
		m_n = 1'b0;
		m_out = '0;
		s1_ins = NOP_INSTR;
		s2_ins = NOP_INSTR;  // same effect as the cleared decoded op
		s2_mem = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			m_mem[i] = '0;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		wait_ready(ready);
		if (ready)
		begin
			compare(o_acc, 8'h00, "o_acc after reset");
			compare(o_outputs, 8'h00, "o_outputs after reset");
			run_test("reset_ldm", 0, 40);
			run_test("alu", 1, 400);
			run_test("store_load", 2, 400);
			run_test("conditions", 3, 400);
			run_test("ports", 4, 300);
			run_test("random_mix", 5, 2000);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
